// ==== hdl/cache_bus_pkg.sv ====
`default_nettype none

package cache_bus_pkg;

	// cache clients sharing the memory port
	localparam int PORT_NUM = 2;

	// client index, also used as the AXI ID
	localparam int PORT_W = (PORT_NUM > 1) ? $clog2(PORT_NUM) : 1;

	// byte addressed, one 32-bit word per beat
	localparam int ADDR_W = 32;
	localparam int DATA_W = 32;
	localparam int STRB_W = DATA_W / 8;

	// burst length field holds beats minus one, up to 16 beats
	localparam int LEN_W = 4;

	// AXI size code for a full 4-byte beat
	localparam logic [2:0] SIZE_WORD = 3'd2;

	// on-chip SRAM depth in words
	localparam int MEM_AW = 8;

	// bridge FSM, one-hot
	typedef enum logic [3:0] {
		ST_IDLE = 4'b0001,
		ST_ADDR = 4'b0010,
		ST_DATA = 4'b0100,
		ST_RESP = 4'b1000
	} bridge_state_t;

endpackage

`default_nettype wire

// ==== hdl/rr_arbiter.sv ====
`default_nettype none
`timescale 1ns/100ps

module rr_arbiter (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]   req_i,
	input  wire                                 take_i,
	output logic [cache_bus_pkg::PORT_NUM-1:0]  grant_o
);
	import cache_bus_pkg::*;

	logic [PORT_W-1:0] ptr_q;
	logic [PORT_W-1:0] win_idx;

	// first requester at or after the pointer wins
	always_comb begin
		int idx;
		logic found;
		grant_o = '0;
		win_idx = '0;
		found = 1'b0;
		for (int off = 0; off < PORT_NUM; off++) begin
			idx = (int'(ptr_q) + off) % PORT_NUM;
			if (!found && req_i[idx]) begin
				found = 1'b1;
				grant_o[idx] = 1'b1;
				win_idx = idx[PORT_W-1:0];
			end
		end
	end

	// winner drops to lowest priority once its grant is taken
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end else if (take_i && |req_i) begin
			if (win_idx == PORT_W'(PORT_NUM - 1))
				ptr_q <= '0;
			else
				ptr_q <= win_idx + 1'b1;
		end
	end

	a_grant_legal: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(grant_o) && ((grant_o & ~req_i) == '0));

endmodule

`default_nettype wire

// ==== hdl/cache_axi_bridge.sv ====
`default_nettype none
`timescale 1ns/100ps

module cache_axi_bridge (
	input  wire                                                           clk,
	input  wire                                                           rst_n,
	// cache side
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             req_valid_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             req_write_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::LEN_W-1:0]   req_len_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::ADDR_W-1:0]  req_addr_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::DATA_W-1:0]  wdata_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::STRB_W-1:0]  wstrb_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             data_ok_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             data_last_i,
	output logic [cache_bus_pkg::PORT_NUM-1:0]                            req_ready_o,
	output logic [cache_bus_pkg::PORT_NUM-1:0]                            data_ok_o,
	output logic [cache_bus_pkg::PORT_NUM-1:0]                            data_last_o,
	output logic [cache_bus_pkg::DATA_W-1:0]                              rdata_o,
	// AXI4 master
	output logic                                                          ar_valid_o,
	output logic [cache_bus_pkg::PORT_W-1:0]                              ar_id_o,
	output logic [cache_bus_pkg::ADDR_W-1:0]                              ar_addr_o,
	output logic [cache_bus_pkg::LEN_W-1:0]                               ar_len_o,
	output logic [2:0]                                                    ar_size_o,
	input  wire                                                           ar_ready_i,
	output logic                                                          aw_valid_o,
	output logic [cache_bus_pkg::PORT_W-1:0]                              aw_id_o,
	output logic [cache_bus_pkg::ADDR_W-1:0]                              aw_addr_o,
	output logic [cache_bus_pkg::LEN_W-1:0]                               aw_len_o,
	output logic [2:0]                                                    aw_size_o,
	input  wire                                                           aw_ready_i,
	output logic                                                          w_valid_o,
	output logic [cache_bus_pkg::DATA_W-1:0]                              w_data_o,
	output logic [cache_bus_pkg::STRB_W-1:0]                              w_strb_o,
	output logic                                                          w_last_o,
	input  wire                                                           w_ready_i,
	input  wire                                                           r_valid_i,
	input  wire [cache_bus_pkg::DATA_W-1:0]                               r_data_i,
	input  wire                                                           r_last_i,
	input  wire [cache_bus_pkg::PORT_W-1:0]                               r_id_i,
	output logic                                                          r_ready_o,
	input  wire                                                           b_valid_i,
	input  wire [cache_bus_pkg::PORT_W-1:0]                               b_id_i,
	output logic                                                          b_ready_o
);
	import cache_bus_pkg::*;

	bridge_state_t state_q, state_d;

	logic [PORT_NUM-1:0] grant;
	logic [PORT_W-1:0]   gnt_idx;
	logic                take;

	// request latched at grant time
	logic [PORT_W-1:0] sel_idx_q;
	logic              sel_write_q;
	logic [LEN_W-1:0]  sel_len_q;
	logic [ADDR_W-1:0] sel_addr_q;

	logic in_data, cur_ok, rd_xfer, wr_xfer;

	assign take = (state_q == ST_IDLE);

	rr_arbiter u_arb (
		.clk     (clk),
		.rst_n   (rst_n),
		.req_i   (req_valid_i),
		.take_i  (take),
		.grant_o (grant)
	);

	assign req_ready_o = grant & {PORT_NUM{take}};

	always_comb begin
		gnt_idx = '0;
		for (int i = 0; i < PORT_NUM; i++) begin
			if (grant[i])
				gnt_idx = PORT_W'(i);
		end
	end

	always_ff @(posedge clk) begin
		if (take && |grant) begin
			sel_idx_q <= gnt_idx;
			sel_write_q <= req_write_i[gnt_idx];
			sel_len_q <= req_len_i[gnt_idx];
			sel_addr_q <= req_addr_i[gnt_idx];
		end
	end

	// FSM
	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: if (|grant) state_d = ST_ADDR;
			ST_ADDR: begin
				if ((ar_valid_o && ar_ready_i) || (aw_valid_o && aw_ready_i))
					state_d = ST_DATA;
			end
			ST_DATA: begin
				if (rd_xfer && r_last_i)
					state_d = ST_IDLE;
				else if (wr_xfer && w_last_o)
					state_d = ST_RESP;
			end
			ST_RESP: if (b_valid_i && b_ready_o) state_d = ST_IDLE;
			default: state_d = ST_IDLE;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n)
			state_q <= ST_IDLE;
		else
			state_q <= state_d;
	end

	// address channels
	assign ar_valid_o = (state_q == ST_ADDR) && !sel_write_q;
	assign aw_valid_o = (state_q == ST_ADDR) && sel_write_q;
	assign ar_id_o = sel_idx_q;
	assign aw_id_o = sel_idx_q;
	assign ar_addr_o = sel_addr_q;
	assign aw_addr_o = sel_addr_q;
	assign ar_len_o = sel_len_q;
	assign aw_len_o = sel_len_q;
	assign ar_size_o = SIZE_WORD;
	assign aw_size_o = SIZE_WORD;

	// selected client drives W and throttles R
	assign in_data = (state_q == ST_DATA);
	assign cur_ok = data_ok_i[sel_idx_q];
	assign w_valid_o = in_data && sel_write_q && cur_ok;
	assign w_last_o = in_data && sel_write_q && data_last_i[sel_idx_q];
	assign w_data_o = wdata_i[sel_idx_q];
	assign w_strb_o = wstrb_i[sel_idx_q];
	assign r_ready_o = in_data && !sel_write_q && cur_ok;
	assign b_ready_o = (state_q == ST_RESP);

	assign wr_xfer = w_valid_o && w_ready_i;
	assign rd_xfer = r_valid_i && r_ready_o;

	// beat handshake back to the owner only
	always_comb begin
		data_ok_o = '0;
		data_last_o = '0;
		data_ok_o[sel_idx_q] = wr_xfer || rd_xfer;
		data_last_o[sel_idx_q] = rd_xfer && r_last_i;
	end

	assign rdata_o = r_data_i;

	property p_hold(logic v, logic r);
		@(posedge clk) disable iff (!rst_n) v && !r |=> v;
	endproperty

	a_state_onehot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(state_q));
	a_addr_excl: assert property (@(posedge clk) disable iff (!rst_n)
		!(ar_valid_o && aw_valid_o));
	a_ar_hold: assert property (p_hold(ar_valid_o, ar_ready_i));
	a_aw_hold: assert property (p_hold(aw_valid_o, aw_ready_i));
	a_w_hold: assert property (p_hold(w_valid_o, w_ready_i));
	// slave responses belong to the transaction in flight
	a_r_id: assert property (@(posedge clk) disable iff (!rst_n)
		r_valid_i |-> r_id_i == sel_idx_q);
	a_b_id: assert property (@(posedge clk) disable iff (!rst_n)
		b_valid_i |-> b_id_i == sel_idx_q);

endmodule

`default_nettype wire

// ==== hdl/axi_sram_slave.sv ====
`default_nettype none
`timescale 1ns/100ps

module axi_sram_slave (
	input  wire                                 clk,
	input  wire                                 rst_n,
	input  wire                                 ar_valid_i,
	input  wire [cache_bus_pkg::PORT_W-1:0]     ar_id_i,
	input  wire [cache_bus_pkg::ADDR_W-1:0]     ar_addr_i,
	input  wire [cache_bus_pkg::LEN_W-1:0]      ar_len_i,
	input  wire [2:0]                           ar_size_i,
	input  wire                                 aw_valid_i,
	input  wire [cache_bus_pkg::PORT_W-1:0]     aw_id_i,
	input  wire [cache_bus_pkg::ADDR_W-1:0]     aw_addr_i,
	input  wire [cache_bus_pkg::LEN_W-1:0]      aw_len_i,
	input  wire [2:0]                           aw_size_i,
	input  wire                                 w_valid_i,
	input  wire [cache_bus_pkg::DATA_W-1:0]     w_data_i,
	input  wire [cache_bus_pkg::STRB_W-1:0]     w_strb_i,
	input  wire                                 w_last_i,
	input  wire                                 r_ready_i,
	input  wire                                 b_ready_i,
	output logic                                ar_ready_o,
	output logic                                aw_ready_o,
	output logic                                w_ready_o,
	output logic                                r_valid_o,
	output logic [cache_bus_pkg::DATA_W-1:0]    r_data_o,
	output logic                                r_last_o,
	output logic [cache_bus_pkg::PORT_W-1:0]    r_id_o,
	output logic                                b_valid_o,
	output logic [cache_bus_pkg::PORT_W-1:0]    b_id_o
);
	import cache_bus_pkg::*;

	logic [DATA_W-1:0] mem [2**MEM_AW];

	logic              rd_act_q, wr_act_q;
	logic [PORT_W-1:0] id_q;
	logic [MEM_AW-1:0] addr_q, nxt_addr;
	logic [LEN_W-1:0]  cnt_q;
	logic              idle, ar_xfer, aw_xfer, r_xfer, w_xfer, last_beat;

	assign idle = !rd_act_q && !wr_act_q && !b_valid_o;
	assign ar_ready_o = idle;
	// read wins if both address channels show up together
	assign aw_ready_o = idle && !ar_valid_i;
	assign w_ready_o = wr_act_q;
	assign r_valid_o = rd_act_q;
	assign last_beat = (cnt_q == '0);
	assign r_last_o = rd_act_q && last_beat;
	assign r_id_o = id_q;
	assign b_id_o = id_q;

	assign ar_xfer = ar_valid_i && ar_ready_o;
	assign aw_xfer = aw_valid_i && aw_ready_o;
	assign r_xfer = r_valid_o && r_ready_i;
	assign w_xfer = w_valid_i && w_ready_o;
	assign nxt_addr = addr_q + 1'b1;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			rd_act_q <= 1'b0;
			wr_act_q <= 1'b0;
			b_valid_o <= 1'b0;
		end else begin
			if (ar_xfer)
				rd_act_q <= 1'b1;
			else if (r_xfer && last_beat)
				rd_act_q <= 1'b0;
			if (aw_xfer)
				wr_act_q <= 1'b1;
			else if (w_xfer && last_beat)
				wr_act_q <= 1'b0;
			if (w_xfer && last_beat)
				b_valid_o <= 1'b1;
			else if (b_ready_i)
				b_valid_o <= 1'b0;
		end
	end

	// burst bookkeeping, word index wraps at the SRAM depth
	always_ff @(posedge clk) begin
		if (ar_xfer) begin
			id_q <= ar_id_i;
			addr_q <= ar_addr_i[MEM_AW+1:2];
			cnt_q <= ar_len_i;
		end else if (aw_xfer) begin
			id_q <= aw_id_i;
			addr_q <= aw_addr_i[MEM_AW+1:2];
			cnt_q <= aw_len_i;
		end else if (r_xfer || w_xfer) begin
			addr_q <= nxt_addr;
			cnt_q <= cnt_q - 1'b1;
		end
	end

	// registered read, next word fetched as each beat leaves
	always_ff @(posedge clk) begin
		if (ar_xfer)
			r_data_o <= mem[ar_addr_i[MEM_AW+1:2]];
		else if (r_xfer)
			r_data_o <= mem[nxt_addr];
	end

	always_ff @(posedge clk) begin
		if (w_xfer) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (w_strb_i[b])
					mem[addr_q][8*b +: 8] <= w_data_i[8*b +: 8];
			end
		end
	end

	a_ar_size: assert property (@(posedge clk) disable iff (!rst_n)
		ar_xfer |-> ar_size_i == SIZE_WORD);
	a_aw_size: assert property (@(posedge clk) disable iff (!rst_n)
		aw_xfer |-> aw_size_i == SIZE_WORD);
	// master's last flag must match the length it announced
	a_w_last: assert property (@(posedge clk) disable iff (!rst_n)
		w_xfer |-> w_last_i == last_beat);

endmodule

`default_nettype wire

// ==== hdl/mem_subsys_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module mem_subsys_top (
	input  wire                                                           clk,
	input  wire                                                           rst_n,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             req_valid_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             req_write_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::LEN_W-1:0]   req_len_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::ADDR_W-1:0]  req_addr_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::DATA_W-1:0]  wdata_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0][cache_bus_pkg::STRB_W-1:0]  wstrb_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             data_ok_i,
	input  wire [cache_bus_pkg::PORT_NUM-1:0]                             data_last_i,
	output logic [cache_bus_pkg::PORT_NUM-1:0]                            req_ready_o,
	output logic [cache_bus_pkg::PORT_NUM-1:0]                            data_ok_o,
	output logic [cache_bus_pkg::PORT_NUM-1:0]                            data_last_o,
	output logic [cache_bus_pkg::DATA_W-1:0]                              rdata_o
);
	import cache_bus_pkg::*;

	// AXI4 between bridge and SRAM
	logic              ar_valid, ar_ready, aw_valid, aw_ready;
	logic [PORT_W-1:0] ar_id, aw_id, r_id, b_id;
	logic [ADDR_W-1:0] ar_addr, aw_addr;
	logic [LEN_W-1:0]  ar_len, aw_len;
	logic [2:0]        ar_size, aw_size;
	logic              w_valid, w_ready, w_last;
	logic [DATA_W-1:0] w_data, r_data;
	logic [STRB_W-1:0] w_strb;
	logic              r_valid, r_ready, r_last, b_valid, b_ready;

	cache_axi_bridge u_bridge (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid_i),
		.req_write_i (req_write_i),
		.req_len_i   (req_len_i),
		.req_addr_i  (req_addr_i),
		.wdata_i     (wdata_i),
		.wstrb_i     (wstrb_i),
		.data_ok_i   (data_ok_i),
		.data_last_i (data_last_i),
		.req_ready_o (req_ready_o),
		.data_ok_o   (data_ok_o),
		.data_last_o (data_last_o),
		.rdata_o     (rdata_o),
		.ar_valid_o  (ar_valid),
		.ar_id_o     (ar_id),
		.ar_addr_o   (ar_addr),
		.ar_len_o    (ar_len),
		.ar_size_o   (ar_size),
		.ar_ready_i  (ar_ready),
		.aw_valid_o  (aw_valid),
		.aw_id_o     (aw_id),
		.aw_addr_o   (aw_addr),
		.aw_len_o    (aw_len),
		.aw_size_o   (aw_size),
		.aw_ready_i  (aw_ready),
		.w_valid_o   (w_valid),
		.w_data_o    (w_data),
		.w_strb_o    (w_strb),
		.w_last_o    (w_last),
		.w_ready_i   (w_ready),
		.r_valid_i   (r_valid),
		.r_data_i    (r_data),
		.r_last_i    (r_last),
		.r_id_i      (r_id),
		.r_ready_o   (r_ready),
		.b_valid_i   (b_valid),
		.b_id_i      (b_id),
		.b_ready_o   (b_ready)
	);

	axi_sram_slave u_sram (
		.clk        (clk),
		.rst_n      (rst_n),
		.ar_valid_i (ar_valid),
		.ar_id_i    (ar_id),
		.ar_addr_i  (ar_addr),
		.ar_len_i   (ar_len),
		.ar_size_i  (ar_size),
		.aw_valid_i (aw_valid),
		.aw_id_i    (aw_id),
		.aw_addr_i  (aw_addr),
		.aw_len_i   (aw_len),
		.aw_size_i  (aw_size),
		.w_valid_i  (w_valid),
		.w_data_i   (w_data),
		.w_strb_i   (w_strb),
		.w_last_i   (w_last),
		.r_ready_i  (r_ready),
		.b_ready_i  (b_ready),
		.ar_ready_o (ar_ready),
		.aw_ready_o (aw_ready),
		.w_ready_o  (w_ready),
		.r_valid_o  (r_valid),
		.r_data_o   (r_data),
		.r_last_o   (r_last),
		.r_id_o     (r_id),
		.b_valid_o  (b_valid),
		.b_id_o     (b_id)
	);

endmodule

`default_nettype wire

// ==== tb/tb_mem_subsys.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_mem_subsys;
	import cache_bus_pkg::*;

	localparam int RESET_CYCLES = 16;
	localparam int RAND_TXNS = 24;
	// single write and read, SRAM fill, random traffic, closing read
	localparam int TXN_COUNT = 2 + 16 + 2 * RAND_TXNS + 1;
	// 16 beats at a generous stall rate plus address, response and gaps
	localparam int TXN_CYCLES = 16 * 8 + 16;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + 32 + TXN_COUNT * TXN_CYCLES;
	localparam logic [PORT_W-1:0] CLI_A = '0;
	localparam logic [PORT_W-1:0] CLI_B = PORT_W'(1);

	logic clk;
	logic rst_n;
	logic [PORT_NUM-1:0]             req_valid, req_write, cli_ok, cli_last;
	logic [PORT_NUM-1:0][LEN_W-1:0]  req_len;
	logic [PORT_NUM-1:0][ADDR_W-1:0] req_addr;
	logic [PORT_NUM-1:0][DATA_W-1:0] wdata;
	logic [PORT_NUM-1:0][STRB_W-1:0] wstrb;
	logic [PORT_NUM-1:0]             req_ready, bus_ok, bus_last;
	logic [DATA_W-1:0]               rdata;
	logic [31:0]                     rng_state;

	// reference model of the transaction in flight
	logic [DATA_W-1:0] shadow [2**MEM_AW];
	logic              seen_req, mon_active, mon_write, granted;
	logic [PORT_W-1:0] mon_port, rr_next, grant_idx;
	logic [LEN_W-1:0]  mon_len;
	logic [LEN_W:0]    mon_beat, mon_len_x;
	logic [MEM_AW-1:0] mon_word;
	logic [DATA_W-1:0] exp_rdata;

	mem_subsys_top uut (
		.clk         (clk),
		.rst_n       (rst_n),
		.req_valid_i (req_valid),
		.req_write_i (req_write),
		.req_len_i   (req_len),
		.req_addr_i  (req_addr),
		.wdata_i     (wdata),
		.wstrb_i     (wstrb),
		.data_ok_i   (cli_ok),
		.data_last_i (cli_last),
		.req_ready_o (req_ready),
		.data_ok_o   (bus_ok),
		.data_last_o (bus_last),
		.rdata_o     (rdata)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [31:0] next_rand();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	task automatic value_mismatch(input string sig, input logic [31:0] expected,
			input logic [31:0] actual);
		$display("** Error at %0t ns: %s expected %h, got %h", $time, sig, expected, actual);
		$display("Errors found");
		$fatal(1);
	endtask

	task automatic rule_broken(input string what);
		$display("** Error at %0t ns: %s", $time, what);
		$display("Errors found");
		$fatal(1);
	endtask

	always_comb begin
		granted = 1'b0;
		grant_idx = '0;
		for (int k = 0; k < PORT_NUM; k++) begin
			if (req_ready[k] && req_valid[k]) begin
				granted = 1'b1;
				grant_idx = PORT_W'(k);
			end
		end
	end

	// beats follow the latched request; write bytes land under their strobes
	always_ff @(posedge clk) begin
		if (!rst_n) begin
			seen_req <= 1'b0;
			mon_active <= 1'b0;
			rr_next <= '0;
			mon_beat <= '0;
		end else begin
			if (req_valid != '0)
				seen_req <= 1'b1;
			if (granted) begin
				mon_active <= 1'b1;
				mon_port <= grant_idx;
				mon_write <= req_write[grant_idx];
				mon_len <= req_len[grant_idx];
				mon_word <= req_addr[grant_idx][MEM_AW+1:2];
				mon_beat <= '0;
				rr_next <= (grant_idx == PORT_W'(PORT_NUM - 1)) ? '0 : grant_idx + 1'b1;
			end else if (bus_ok != '0) begin
				if (mon_write) begin
					for (int b = 0; b < STRB_W; b++) begin
						if (wstrb[mon_port][b])
							shadow[mon_word][8*b +: 8] <= wdata[mon_port][8*b +: 8];
					end
				end
				mon_word <= mon_word + 1'b1;
				mon_beat <= mon_beat + 1'b1;
			end
		end
	end

	assign exp_rdata = shadow[mon_word];
	assign mon_len_x = {1'b0, mon_len};

	a_quiet_start: assert property (@(posedge clk) disable iff (!rst_n)
		(!seen_req && req_valid == '0) |-> {req_ready, bus_ok, bus_last} == '0)
		else value_mismatch("{req_ready_o,data_ok_o,data_last_o}", 32'd0,
			32'($sampled({req_ready, bus_ok, bus_last})));
	a_one_ready: assert property (@(posedge clk) disable iff (!rst_n)
		$onehot0(req_ready) && (req_ready & ~req_valid) == '0)
		else rule_broken("req_ready_o high for more than one client or for an idle one");
	// contested grant goes to the client after the last winner
	a_rr_turn: assert property (@(posedge clk) disable iff (!rst_n)
		(req_valid == '1 && granted) |-> req_ready == (PORT_NUM'(1) << rr_next))
		else value_mismatch("req_ready_o", 32'(PORT_NUM'(1) << $sampled(rr_next)),
			32'($sampled(req_ready)));
	a_ok_owner: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_ok != '0) |-> mon_active && bus_ok == (PORT_NUM'(1) << mon_port))
		else value_mismatch("data_ok_o", 32'(PORT_NUM'(1) << $sampled(mon_port)),
			32'($sampled(bus_ok)));
	a_last_gated: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_last & ~bus_ok) == '0)
		else rule_broken("data_last_o high without data_ok_o");
	a_read_data: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_ok != '0 && !mon_write) |-> rdata == exp_rdata)
		else value_mismatch("rdata_o", $sampled(exp_rdata), $sampled(rdata));
	a_read_last: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_ok != '0 && !mon_write) |-> bus_last[mon_port] == (mon_beat == mon_len_x))
		else value_mismatch("data_last_o", 32'($sampled(mon_beat == mon_len_x)),
			32'($sampled(bus_last[mon_port])));
	a_beat_max: assert property (@(posedge clk) disable iff (!rst_n)
		(bus_ok != '0) |-> mon_beat <= mon_len_x)
		else rule_broken("data_ok_o seen for more than len+1 beats");
	a_beat_total: assert property (@(posedge clk) disable iff (!rst_n)
		(granted && mon_active) |-> mon_beat == mon_len_x + 1'b1)
		else value_mismatch("data_ok_o beat count", 32'($sampled(mon_len_x + 1'b1)),
			32'($sampled(mon_beat)));

	task automatic cache_access(input logic [PORT_W-1:0] p, input logic wr,
			input logic [LEN_W-1:0] len, input logic [ADDR_W-1:0] addr,
			input logic full_strb, input logic stalls);
		int beat;
		logic showing;
		logic [31:0] r;
		beat = 0;
		showing = 1'b0;
		@(negedge clk);
		req_valid[p] = 1'b1;
		req_write[p] = wr;
		req_len[p] = len;
		req_addr[p] = addr;
		cli_ok[p] = 1'b0;
		cli_last[p] = 1'b0;
		do
			@(posedge clk);
		while (!req_ready[p]);
		while (beat <= int'(len)) begin
			@(negedge clk);
			req_valid[p] = 1'b0;
			// an offered write beat stays until it is taken
			if (!(wr && showing)) begin
				r = next_rand();
				if (stalls && r[31:30] == 2'b00) begin
					cli_ok[p] = 1'b0;
				end else begin
					cli_ok[p] = 1'b1;
					showing = 1'b1;
					if (wr) begin
						wdata[p] = next_rand();
						wstrb[p] = full_strb ? '1 : r[29:26];
						cli_last[p] = (beat == int'(len));
					end
				end
			end
			@(posedge clk);
			if (bus_ok[p]) begin
				beat++;
				showing = 1'b0;
			end
		end
	endtask

	task automatic client_pause(input logic [PORT_W-1:0] p, input int cycles);
		repeat (cycles) begin
			@(negedge clk);
			cli_ok[p] = 1'b0;
			cli_last[p] = 1'b0;
		end
	endtask

	task automatic random_traffic(input logic [PORT_W-1:0] p);
		logic [31:0] r;
		for (int n = 0; n < RAND_TXNS; n++) begin
			r = next_rand();
			cache_access(p, r[31], r[30:27], next_rand() & 32'hffff_fffc, r[26], 1'b1);
			client_pause(p, int'(r[25:24]));
		end
	endtask

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		rule_broken("watchdog expired before all transactions finished");
	end

	initial begin
		rng_state = 32'h0afa_dfaa;
		rst_n = 1'b0;
		req_valid = '0;
		req_write = '0;
		req_len = '0;
		req_addr = '0;
		wdata = '0;
		wstrb = '0;
		cli_ok = '0;
		cli_last = '0;
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		// idle bus for a while before the first request
		repeat (6) @(negedge clk);
		cache_access(CLI_A, 1'b1, 4'd0, 32'h0000_0150, 1'b1, 1'b0);
		cache_access(CLI_A, 1'b0, 4'd0, 32'h0000_0150, 1'b1, 1'b0);
		// fill every word so later reads have known contents
		for (int i = 0; i < 16; i++)
			cache_access(CLI_A, 1'b1, 4'd15, 32'(i * 64), 1'b1, 1'b0);
		fork
			random_traffic(CLI_A);
			random_traffic(CLI_B);
		join
		// closing read waits out any pending write response
		cache_access(CLI_B, 1'b0, 4'd0, 32'h0000_03fc, 1'b1, 1'b1);
		// a few idle cycles so a stray beat still meets the checks
		repeat (4) @(negedge clk);
		$display("No errors");
		$finish;
	end

endmodule

`default_nettype wire

// ==== list.f ====
hdl/cache_bus_pkg.sv
hdl/rr_arbiter.sv
hdl/cache_axi_bridge.sv
hdl/axi_sram_slave.sv
hdl/mem_subsys_top.sv
tb/tb_mem_subsys.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       := tb_mem_subsys
FILELIST  := list.f
FLAGS     := --binary --timing --assert --timescale 1ns/100ps -j 0
OBJ_DIR   := obj_dir

.PHONY: help test clean

help:
	@echo "make test   build the testbench with Verilator and run it"
	@echo "make clean  remove the build directory"
	@echo "make help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
